// ==== logic/daq_macros.svh ====
`ifndef DAQ_MACROS_SVH
`define DAQ_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Fixed ASIC timing minimums, counted in Clk cycles
////////////////////////////////////////////////////////////////////////////

// Wake-up of the clock LVDS receivers before reset is released
`define TIME_POWER_RESET 16'd8

// Slow clock and fast clock ticks for internal management after reset
`define TIME_RESET_START 16'd40

// Width of the readout request
`define TIME_SRO 16'd16

////////////////////////////////////////////////////////////////////////////
// Record marker words
////////////////////////////////////////////////////////////////////////////

`define MARK_TRIG_ID 8'hF1     // Upper byte, first trigger-ID word
`define MARK_COUNT   8'hCC     // Upper byte, first count word

`define WORD_TAIL 16'hFF45     // Opens the end-of-run trailer
`define WORD_END  16'h45FF     // Closes the end-of-run trailer

`endif

// ==== logic/DaqPkg.sv ====
package DaqPkg;

	// Acquisition sequencer states, order matters for the power decode
	typedef enum logic [4:0] {
		Idle           = 5'd0,
		ChipReset      = 5'd1,
		PowerOn        = 5'd2,
		Release        = 5'd3,
		WaitStart      = 5'd4,
		Acquire        = 5'd5,
		WaitRead       = 5'd6,
		StartReadoutSt = 5'd7,
		WaitReadDone   = 5'd8,
		OnceEndSt      = 5'd9,
		OutTrigId1     = 5'd10,
		OutTrigId2     = 5'd11,
		WaitDataEnd    = 5'd12,
		OutTail        = 5'd13,
		OutCount1      = 5'd14,
		OutCount2      = 5'd15,
		OutCount3      = 5'd16,
		FifoLatency    = 5'd17,
		AllDoneSt      = 5'd18
	} DaqState;

	// Host register map
	typedef enum logic [1:0] {
		Control     = 2'd0,     // Bit 0 is the run enable
		AcqTime     = 2'd1,
		EndHold     = 2'd2,
		DataEndWait = 2'd3
	} CfgAddr;

endpackage

// ==== logic/DaqConfigRegs.sv ====
module DaqConfigRegs (
	input  logic           Clk,
	input  logic           reset_n,
	input  logic           CfgWrite,
	input  DaqPkg::CfgAddr CfgAddr,
	input  logic [15:0]    CfgData,
	output logic [15:0]    CfgReadData,
	output logic           ModuleStart,
	output logic [15:0]    AcquisitionTime,
	output logic [15:0]    EndHoldTime,
	output logic [15:0]    DataEndWait
);
	import DaqPkg::*;

	localparam logic [15:0] ControlInit = 16'd0;
	localparam logic [15:0] AcqTimeInit = 16'd8;
	localparam logic [15:0] EndHoldInit = 16'd4;
	localparam logic [15:0] EndWaitInit = 16'd1600;   // Drain time before the trailer

	logic [15:0] ControlReg;
	logic [15:0] AcqTimeReg;
	logic [15:0] EndHoldReg;
	logic [15:0] EndWaitReg;

	// Host writes, taken on the strobe edge
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			ControlReg <= ControlInit;
			AcqTimeReg <= AcqTimeInit;
			EndHoldReg <= EndHoldInit;
			EndWaitReg <= EndWaitInit;
		end else if (CfgWrite) begin
			case (CfgAddr)
				Control:              ControlReg <= CfgData;
				AcqTime:              AcqTimeReg <= CfgData;
				EndHold:              EndHoldReg <= CfgData;
				DaqPkg::DataEndWait:  EndWaitReg <= CfgData;
				default:              ControlReg <= ControlReg;
			endcase
		end
	end

	// Readback follows the address without a clock
	always_comb begin
		case (CfgAddr)
			Control:              CfgReadData = ControlReg;
			AcqTime:              CfgReadData = AcqTimeReg;
			EndHold:              CfgReadData = EndHoldReg;
			DaqPkg::DataEndWait:  CfgReadData = EndWaitReg;
			default:              CfgReadData = 16'h0000;
		endcase
	end

	assign ModuleStart     = ControlReg[0];   // Run enable
	assign AcquisitionTime = AcqTimeReg;
	assign EndHoldTime     = EndHoldReg;
	assign DataEndWait     = EndWaitReg;

endmodule

// ==== logic/AsicInputSync.sv ====
module AsicInputSync (
	input  logic Clk,
	input  logic reset_n,
	input  logic AcqStart,
	input  logic ChipSatB,
	input  logic EndReadout,
	input  logic MicrorocDataEn,
	output logic TrigRise,
	output logic ChipFull,
	output logic ReadReady,
	output logic EndRead,
	output logic HitSeen
);
	// Pin order {AcqStart, ChipSatB, EndReadout, MicrorocDataEn}
	localparam logic [3:0] PinIdle = 4'b0100;   // ChipSatB is active low

	logic [3:0] PinRaw;
	logic [3:0] PinMeta;    // First synchronizer stage
	logic [3:0] PinSync;    // Second stage, safe to use
	logic [3:0] PinLast;    // Previous synced value for edges

	assign PinRaw = {AcqStart, ChipSatB, EndReadout, MicrorocDataEn};

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			PinMeta <= PinIdle;
			PinSync <= PinIdle;
			PinLast <= PinIdle;
		end else begin
			PinMeta <= PinRaw;
			PinSync <= PinMeta;
			PinLast <= PinSync;
		end
	end

	// Edge pulses, one Clk cycle wide
	assign TrigRise  = PinSync[3] & ~PinLast[3];   // External trigger
	assign ChipFull  = ~PinSync[2] & PinLast[2];   // One or more ASICs full
	assign ReadReady = PinSync[2] & ~PinLast[2];   // Readout may start
	assign EndRead   = PinSync[1];
	assign HitSeen   = PinSync[0] & ~PinLast[0];   // ASIC sent data

endmodule

// ==== logic/SlaveDaq.sv ====
`include "daq_macros.svh"

module SlaveDaq (
	input  logic            Clk,
	input  logic            reset_n,
	input  logic            ModuleStart,
	input  logic            TrigRise,
	input  logic            ChipFull,
	input  logic            ReadReady,
	input  logic            EndRead,
	input  logic            HitSeen,
	input  logic            DataTransmitDone,
	input  logic [15:0]     AcquisitionTime,
	input  logic [15:0]     EndHoldTime,
	input  logic [15:0]     DataEndWait,
	output DaqPkg::DaqState State,
	output logic            InternalEn,
	output logic [23:0]     TrigCount,
	output logic            ResetB,
	output logic            StartAcq,
	output logic            ForceExternalRaz,
	output logic            StartReadout,
	output logic            PwrOnA,
	output logic            PwrOnD,
	output logic            PwrOnDac,
	output logic            OnceEnd,
	output logic            AllDone
);
	import DaqPkg::*;

	logic [15:0] DelayCount;   // Shared by every timed state
	logic        RunEn;        // Triggers are counted while set
	logic        HitFlag;      // ASIC produced data since the last trigger

	// Order of the record word states
	function automatic DaqState WordNext(input DaqState Cur);
		case (Cur)
			OutTrigId1: WordNext = OutTrigId2;
			OutTrigId2: WordNext = WaitStart;
			OutTail:    WordNext = OutCount1;
			OutCount1:  WordNext = OutCount2;
			OutCount2:  WordNext = OutCount3;
			default:    WordNext = FifoLatency;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Acquisition sequencer
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			State            <= Idle;
			DelayCount       <= 16'd0;
			TrigCount        <= 24'd0;
			RunEn            <= 1'b0;
			HitFlag          <= 1'b0;
			InternalEn       <= 1'b0;
			ResetB           <= 1'b1;
			StartAcq         <= 1'b0;
			ForceExternalRaz <= 1'b1;
			StartReadout     <= 1'b0;
			OnceEnd          <= 1'b0;
			AllDone          <= 1'b0;
		end else begin
			OnceEnd <= 1'b0;   // Pulse unless set below
			if (HitSeen)
				HitFlag <= 1'b1;
			if (RunEn && ModuleStart && TrigRise)
				TrigCount <= TrigCount + 24'd1;

			case (State)
				Idle: begin
					if (ModuleStart) begin
						ResetB    <= 1'b0;   // Hold the ASIC digital part in reset
						TrigCount <= 24'd0;
						HitFlag   <= 1'b0;
						State     <= ChipReset;
					end
				end
				ChipReset: State <= PowerOn;
				PowerOn: begin
					if (DelayCount < `TIME_POWER_RESET) begin
						DelayCount <= DelayCount + 16'd1;
					end else begin
						DelayCount <= 16'd0;
						ResetB     <= 1'b1;
						State      <= Release;
					end
				end
				Release: begin
					if (DelayCount < `TIME_RESET_START) begin
						DelayCount <= DelayCount + 16'd1;
					end else begin
						DelayCount <= 16'd0;
						RunEn      <= 1'b1;
						State      <= WaitStart;
					end
				end
				WaitStart: begin
					if (!ModuleStart) begin
						RunEn <= 1'b0;   // Count is frozen from here on
						State <= WaitDataEnd;
					end else if (TrigRise) begin
						StartAcq         <= 1'b1;
						ForceExternalRaz <= 1'b0;
						HitFlag          <= 1'b0;
						State            <= Acquire;
					end
				end
				Acquire: begin
					// Window closes on time or when a chip fills up
					if (DelayCount >= AcquisitionTime || ChipFull) begin
						DelayCount       <= 16'd0;
						StartAcq         <= 1'b0;
						ForceExternalRaz <= 1'b1;
						State            <= WaitRead;
					end else begin
						DelayCount <= DelayCount + 16'd1;
					end
				end
				WaitRead: begin
					if (ReadReady) begin
						StartReadout <= 1'b1;
						State        <= StartReadoutSt;
					end
				end
				StartReadoutSt: begin
					if (DelayCount < `TIME_SRO) begin
						DelayCount <= DelayCount + 16'd1;
					end else begin
						DelayCount   <= 16'd0;
						StartReadout <= 1'b0;
						State        <= WaitReadDone;
					end
				end
				WaitReadDone: begin
					if (EndRead)
						State <= OnceEndSt;
				end
				OnceEndSt: begin
					if (DelayCount < EndHoldTime) begin
						DelayCount <= DelayCount + 16'd1;
					end else begin
						DelayCount <= 16'd0;
						if (HitFlag) begin
							State <= OutTrigId1;   // Append the trigger ID
						end else begin
							OnceEnd <= 1'b1;
							State   <= WaitStart;
						end
					end
				end
				// Each record word takes two cycles, enable in the second
				OutTrigId1, OutTrigId2, OutTail, OutCount1, OutCount2, OutCount3: begin
					if (DelayCount == 16'd0) begin
						DelayCount <= 16'd1;
						InternalEn <= 1'b1;
					end else begin
						DelayCount <= 16'd0;
						InternalEn <= 1'b0;
						State      <= WordNext(State);
						if (State == OutTrigId2)
							OnceEnd <= 1'b1;
						if (State == OutCount3)
							AllDone <= 1'b1;
					end
				end
				WaitDataEnd: begin
					if (DelayCount < DataEndWait) begin
						DelayCount <= DelayCount + 16'd1;
					end else begin
						DelayCount <= 16'd0;
						State      <= OutTail;
					end
				end
				FifoLatency: begin
					if (DelayCount == 16'd0) begin
						DelayCount <= 16'd1;
					end else begin
						DelayCount <= 16'd0;
						State      <= AllDoneSt;
					end
				end
				AllDoneSt: begin
					if (DataTransmitDone) begin
						AllDone <= 1'b0;
						State   <= Idle;
					end
				end
				default: State <= Idle;
			endcase
		end
	end

	// Power pulsing, decoded from the state order
	assign PwrOnD   = State inside {[PowerOn:OutTrigId2]};
	assign PwrOnA   = State inside {[ChipReset:OutTrigId2]};
	assign PwrOnDac = PwrOnA;   // DAC follows the analogue part

endmodule

// ==== logic/DaqWordMux.sv ====
`include "daq_macros.svh"

module DaqWordMux (
	input  DaqPkg::DaqState State,
	input  logic            InternalEn,
	input  logic [23:0]     TrigCount,
	input  logic [15:0]     MicrorocData,
	input  logic            MicrorocDataEn,
	output logic [15:0]     DaqData,
	output logic            DaqDataEn
);
	import DaqPkg::*;

	logic [15:0] RecordWord;

	////////////////////////////////////////////////////////////////////////////
	// Words made by the sequencer
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (State)
			OutTrigId1: RecordWord = {`MARK_TRIG_ID, TrigCount[23:16]};
			OutTrigId2: RecordWord = TrigCount[15:0];
			OutTail:    RecordWord = `WORD_TAIL;
			OutCount1:  RecordWord = {`MARK_COUNT, TrigCount[23:16]};
			OutCount2:  RecordWord = TrigCount[15:0];
			OutCount3:  RecordWord = `WORD_END;
			default:    RecordWord = 16'h0000;
		endcase
	end

	// Record words win, ASIC data passes with no latency otherwise
	always_comb begin
		if (InternalEn) begin
			DaqData   = RecordWord;
			DaqDataEn = 1'b1;
		end else begin
			DaqData   = MicrorocData;
			DaqDataEn = MicrorocDataEn;
		end
	end

endmodule

// ==== logic/DifDaqTop.sv ====
module DifDaqTop (
	input  logic           Clk,
	input  logic           reset_n,
	// Host register port
	input  logic           CfgWrite,
	input  DaqPkg::CfgAddr CfgAddr,
	input  logic [15:0]    CfgData,
	output logic [15:0]    CfgReadData,
	// ASIC status and data
	input  logic           AcqStart,
	input  logic           ChipSatB,
	input  logic           EndReadout,
	input  logic [15:0]    MicrorocData,
	input  logic           MicrorocDataEn,
	// Downstream data
	input  logic           DataTransmitDone,
	output logic [15:0]    DaqData,
	output logic           DaqDataEn,
	// ASIC control
	output logic           ResetB,
	output logic           StartAcq,
	output logic           ForceExternalRaz,
	output logic           StartReadout,
	output logic           PwrOnA,
	output logic           PwrOnD,
	output logic           PwrOnDac,
	output logic           OnceEnd,
	output logic           AllDone
);
	import DaqPkg::*;

	logic        ModuleStart;
	logic [15:0] AcquisitionTime;
	logic [15:0] EndHoldTime;
	logic [15:0] DataEndWait;
	logic        TrigRise;
	logic        ChipFull;
	logic        ReadReady;
	logic        EndRead;
	logic        HitSeen;
	DaqState     State;
	logic        InternalEn;
	logic [23:0] TrigCount;

	DaqConfigRegs DaqConfigRegs_i (
		.Clk, .reset_n, .CfgWrite, .CfgAddr, .CfgData, .CfgReadData,
		.ModuleStart, .AcquisitionTime, .EndHoldTime, .DataEndWait
	);

	AsicInputSync AsicInputSync_i (
		.Clk, .reset_n, .AcqStart, .ChipSatB, .EndReadout, .MicrorocDataEn,
		.TrigRise, .ChipFull, .ReadReady, .EndRead, .HitSeen
	);

	SlaveDaq SlaveDaq_i (
		.Clk, .reset_n, .ModuleStart, .TrigRise, .ChipFull, .ReadReady, .EndRead,
		.HitSeen, .DataTransmitDone, .AcquisitionTime, .EndHoldTime, .DataEndWait,
		.State, .InternalEn, .TrigCount, .ResetB, .StartAcq, .ForceExternalRaz,
		.StartReadout, .PwrOnA, .PwrOnD, .PwrOnDac, .OnceEnd, .AllDone
	);

	// Raw ASIC data goes straight to the mux
	DaqWordMux DaqWordMux_i (
		.State, .InternalEn, .TrigCount, .MicrorocData, .MicrorocDataEn,
		.DaqData, .DaqDataEn
	);

endmodule

// ==== verif/DifDaq_chk.sv ====
`include "daq_macros.svh"

module DifDaqChk (
	input  logic            Clk,
	input  logic            reset_n,
	input  DaqPkg::DaqState State,
	input  logic            DataTransmitDone,
	input  logic            ResetB,
	input  logic            StartAcq,
	input  logic            StartReadout,
	input  logic            PwrOnD,
	input  logic            OnceEnd,
	input  logic            AllDone
);
	timeunit 1ns;
	timeprecision 100ps;
	import DaqPkg::*;

	logic [15:0] SroHigh;    // Cycles StartReadout has been high
	logic [15:0] ResetLow;   // Cycles ResetB has been low

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			SroHigh  <= 16'd0;
			ResetLow <= 16'd0;
		end else begin
			SroHigh  <= StartReadout ? SroHigh + 16'd1 : 16'd0;
			ResetLow <= ResetB ? 16'd0 : ResetLow + 16'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer timing
	////////////////////////////////////////////////////////////////////////////
	SroWidth: assert property (@(posedge Clk) disable iff (!reset_n)
		$fell(StartReadout) |-> SroHigh == `TIME_SRO + 16'd1)
		else $error("StartReadout pulse had the wrong length");
	SroMax: assert property (@(posedge Clk) disable iff (!reset_n)
		StartReadout |-> SroHigh <= `TIME_SRO)
		else $error("StartReadout stayed high too long");
	AcqPowered: assert property (@(posedge Clk) disable iff (!reset_n)
		StartAcq |-> PwrOnD)
		else $error("StartAcq high while the digital supply is off");
	AllDoneHold: assert property (@(posedge Clk) disable iff (!reset_n)
		AllDone && !DataTransmitDone |=> AllDone)
		else $error("AllDone dropped before DataTransmitDone");
	OnceEndPulse: assert property (@(posedge Clk) disable iff (!reset_n)
		OnceEnd |=> !OnceEnd)
		else $error("OnceEnd lasted more than one cycle");
	OnceEndState: assert property (@(posedge Clk) disable iff (!reset_n)
		OnceEnd |-> State == WaitStart)
		else $error("OnceEnd outside the return to WaitStart");
	ResetWidth: assert property (@(posedge Clk) disable iff (!reset_n)
		$rose(ResetB) |-> ResetLow == `TIME_POWER_RESET + 16'd2)
		else $error("ResetB low phase had the wrong length");
	ResetMax: assert property (@(posedge Clk) disable iff (!reset_n)
		!ResetB |-> ResetLow <= `TIME_POWER_RESET + 16'd1)
		else $error("ResetB stayed low too long");

endmodule

bind SlaveDaq DifDaqChk DifDaqChk_i (
	.Clk, .reset_n, .State, .DataTransmitDone, .ResetB, .StartAcq,
	.StartReadout, .PwrOnD, .OnceEnd, .AllDone
);

// ==== verif/DifDaqTb.sv ====
`include "daq_macros.svh"

module DifDaqTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          ClkHalf       = 10;
	localparam int          DriveDelay    = 2;
	localparam int          ResetCycles   = 8;
	localparam int          SyncLatency   = 2;     // Pin change to edge pulse
	localparam int          AcqCycles     = 8;
	localparam int          EndWaitCycles = 20;
	localparam int          NumTriggers   = 6;
	localparam int          WaitLimit     = 200;
	localparam int unsigned Seed          = 32'hc787_5c60;

	logic           Clk;
	logic           reset_n;
	logic           CfgWrite;
	DaqPkg::CfgAddr CfgAddr;
	logic [15:0]    CfgData;
	logic [15:0]    CfgReadData;
	logic           AcqStart;
	logic           ChipSatB;
	logic           EndReadout;
	logic [15:0]    MicrorocData;
	logic           MicrorocDataEn;
	logic           DataTransmitDone;
	logic [15:0]    DaqData;
	logic           DaqDataEn;
	logic           ResetB;
	logic           StartAcq;
	logic           ForceExternalRaz;
	logic           StartReadout;
	logic           PwrOnA;
	logic           PwrOnD;
	logic           PwrOnDac;
	logic           OnceEnd;
	logic           AllDone;
	logic [23:0]    TrigTotal;   // Own count of triggers sent

	import DaqPkg::*;

	DifDaqTop DifDaqTop_i (
		.Clk, .reset_n, .CfgWrite, .CfgAddr, .CfgData, .CfgReadData,
		.AcqStart, .ChipSatB, .EndReadout, .MicrorocData, .MicrorocDataEn,
		.DataTransmitDone, .DaqData, .DaqDataEn, .ResetB, .StartAcq,
		.ForceExternalRaz, .StartReadout, .PwrOnA, .PwrOnD, .PwrOnDac,
		.OnceEnd, .AllDone
	);

	initial begin
		Clk = 1'b0;
		forever #ClkHalf Clk = ~Clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic stopWithError(input string Why);
		$display("%s", Why);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic reportMismatch(input string Name, input logic [31:0] Got,
			input logic [31:0] Exp);
		stopWithError($sformatf("Mismatch %s: got 0x%h, expected 0x%h", Name, Got, Exp));
	endtask

	task automatic checkBit(input string Name, input logic Got, input logic Exp);
		assert (Got === Exp) else reportMismatch(Name, 32'(Got), 32'(Exp));
	endtask

	task automatic nextCycle();
		@(posedge Clk);
		#DriveDelay;   // Drive point
	endtask

	function automatic logic probe(input string Name);
		case (Name)
			"ResetB":       return ResetB;
			"StartAcq":     return StartAcq;
			"StartReadout": return StartReadout;
			"DaqDataEn":    return DaqDataEn;
			"OnceEnd":      return OnceEnd;
			"AllDone":      return AllDone;
			default:        return 1'bx;
		endcase
	endfunction

	task automatic waitLevel(input string Name, input logic Level, input int Limit);
		int Count;
		Count = 0;
		while (probe(Name) !== Level) begin
			if (Count == Limit)
				stopWithError($sformatf("Timeout waiting for %s to reach %0b", Name, Level));
			else begin
				nextCycle();
				Count++;
			end
		end
	endtask

	task automatic writeReg(input DaqPkg::CfgAddr Addr, input logic [15:0] Value);
		CfgAddr  = Addr;
		CfgData  = Value;
		CfgWrite = 1'b1;
		nextCycle();
		CfgWrite = 1'b0;
	endtask

	task automatic checkReg(input DaqPkg::CfgAddr Addr, input logic [15:0] Exp);
		CfgAddr = Addr;
		#1;
		assert (CfgReadData == Exp) else reportMismatch("CfgReadData", 32'(CfgReadData), 32'(Exp));
	endtask

	// First word of a record is awaited, the others follow one idle cycle later
	task automatic expectWord(input logic [15:0] Exp, input bit First);
		if (First) begin
			waitLevel("DaqDataEn", 1'b1, WaitLimit);
		end else begin
			nextCycle();
			assert (!DaqDataEn) else stopWithError("DaqDataEn high between two record words");
			nextCycle();
			assert (DaqDataEn) else stopWithError("Record word missing after the idle cycle");
		end
		assert (DaqData == Exp) else reportMismatch("DaqData", 32'(DaqData), 32'(Exp));
	endtask

	task automatic waitOnceEndQuiet();
		int Count;
		Count = 0;
		while (!OnceEnd) begin
			assert (!DaqDataEn) else stopWithError("Unexpected word on DaqData before OnceEnd");
			if (Count == WaitLimit)
				stopWithError("Timeout waiting for OnceEnd");
			else begin
				nextCycle();
				Count++;
			end
		end
	endtask

	// Gap between triggers, the output must stay silent
	task automatic idleCycles(input int Cycles);
		repeat (Cycles) begin
			nextCycle();
			assert (!DaqDataEn) else stopWithError("Unexpected word on DaqData between triggers");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One trigger with the ASIC side modelled here
	////////////////////////////////////////////////////////////////////////////
	task automatic runAcquisition(input bit WithHits, input bit EarlyFull);
		int          Width;
		int          ExpWidth;
		int          Idx;
		logic [15:0] Word;
		AcqStart  = 1'b1;
		TrigTotal = TrigTotal + 24'd1;
		waitLevel("StartAcq", 1'b1, WaitLimit);
		AcqStart = 1'b0;
		checkBit("PwrOnA", PwrOnA, 1'b1);     // Supplies are on while acquiring
		checkBit("PwrOnD", PwrOnD, 1'b1);
		checkBit("PwrOnDac", PwrOnDac, 1'b1);
		if (EarlyFull)
			ChipSatB = 1'b0;   // Chip fills up inside the window
		ExpWidth = EarlyFull ? SyncLatency + 1 : AcqCycles + 1;
		Width    = 1;
		nextCycle();
		while (StartAcq && Width < WaitLimit) begin
			Width++;
			nextCycle();
		end
		assert (Width == ExpWidth) else reportMismatch("StartAcq cycles", Width, ExpWidth);

		ChipSatB = 1'b0;
		repeat (3) nextCycle();
		ChipSatB = 1'b1;     // Readout may start
		waitLevel("StartReadout", 1'b1, WaitLimit);
		if (WithHits) begin
			for (Idx = 0; Idx < 3; Idx++) begin
				Word           = 16'($urandom);
				MicrorocData   = Word;
				MicrorocDataEn = 1'b1;
				#1;
				checkBit("DaqDataEn", DaqDataEn, 1'b1);
				assert (DaqData == Word) else reportMismatch("DaqData", 32'(DaqData), 32'(Word));
				nextCycle();
			end
			MicrorocDataEn = 1'b0;
		end
		waitLevel("StartReadout", 1'b0, WaitLimit);
		EndReadout = 1'b1;
		nextCycle();
		EndReadout = 1'b0;

		if (WithHits) begin
			expectWord({`MARK_TRIG_ID, TrigTotal[23:16]}, 1'b1);
			expectWord(TrigTotal[15:0], 1'b0);
			nextCycle();
		end
		waitOnceEndQuiet();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int Idx;
		bit Hits;
		void'($urandom(Seed));
		reset_n          = 1'b0;
		CfgWrite         = 1'b0;
		CfgAddr          = Control;
		CfgData          = 16'h0000;
		AcqStart         = 1'b0;
		ChipSatB         = 1'b1;
		EndReadout       = 1'b0;
		MicrorocData     = 16'h0000;
		MicrorocDataEn   = 1'b0;
		DataTransmitDone = 1'b0;
		TrigTotal        = 24'd0;
		repeat (ResetCycles) @(posedge Clk);
		#DriveDelay;
		reset_n = 1'b1;

		checkBit("ResetB", ResetB, 1'b1);
		checkBit("ForceExternalRaz", ForceExternalRaz, 1'b1);
		checkBit("StartAcq", StartAcq, 1'b0);
		checkBit("StartReadout", StartReadout, 1'b0);
		checkBit("OnceEnd", OnceEnd, 1'b0);
		checkBit("AllDone", AllDone, 1'b0);
		checkBit("DaqDataEn", DaqDataEn, 1'b0);
		checkBit("PwrOnA", PwrOnA, 1'b0);
		checkBit("PwrOnD", PwrOnD, 1'b0);
		checkBit("PwrOnDac", PwrOnDac, 1'b0);

		checkReg(Control, 16'h0000);     // Reset values first
		checkReg(AcqTime, 16'd8);
		checkReg(EndHold, 16'd4);
		checkReg(DataEndWait, 16'd1600);
		nextCycle();
		writeReg(AcqTime, 16'h5A5A);     // Differs from the reset value
		checkReg(AcqTime, 16'h5A5A);
		nextCycle();
		writeReg(AcqTime, 16'(AcqCycles));
		checkReg(AcqTime, 16'(AcqCycles));
		nextCycle();
		writeReg(EndHold, 16'd6);
		checkReg(EndHold, 16'd6);
		nextCycle();
		writeReg(DataEndWait, 16'(EndWaitCycles));
		checkReg(DataEndWait, 16'(EndWaitCycles));
		nextCycle();
		writeReg(Control, 16'h0001);
		checkReg(Control, 16'h0001);

		waitLevel("ResetB", 1'b0, WaitLimit);
		waitLevel("ResetB", 1'b1, WaitLimit);
		repeat (`TIME_RESET_START + 1) nextCycle();   // Release phase

		for (Idx = 0; Idx < NumTriggers; Idx++) begin
			Hits = (Idx == 0) ? 1'b1 : (Idx == 1) ? 1'b0 : 1'($urandom % 2);
			idleCycles(2 + $urandom % 8);
			runAcquisition(Hits, Idx == 1);
		end

		// End of run and trailer
		writeReg(Control, 16'h0000);
		expectWord(`WORD_TAIL, 1'b1);
		expectWord({`MARK_COUNT, TrigTotal[23:16]}, 1'b0);
		expectWord(TrigTotal[15:0], 1'b0);
		expectWord(`WORD_END, 1'b0);
		waitLevel("AllDone", 1'b1, WaitLimit);
		repeat (5) begin
			nextCycle();
			assert (AllDone) else stopWithError("AllDone dropped before DataTransmitDone");
		end
		DataTransmitDone = 1'b1;
		nextCycle();
		DataTransmitDone = 1'b0;
		checkBit("AllDone", AllDone, 1'b0);
		checkBit("PwrOnA", PwrOnA, 1'b0);
		checkBit("PwrOnD", PwrOnD, 1'b0);
		checkBit("PwrOnDac", PwrOnDac, 1'b0);
		nextCycle();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== DifDaq.f ====
+incdir+logic
logic/DaqPkg.sv
logic/DaqConfigRegs.sv
logic/AsicInputSync.sv
logic/SlaveDaq.sv
logic/DaqWordMux.sv
logic/DifDaqTop.sv
verif/DifDaq_chk.sv
verif/DifDaqTb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the DifDaq simulation with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f DifDaq.f --top-module DifDaqTb -o DifDaqSim \
	&& ./obj_dir/DifDaqSim | tee /dev/stderr | grep -q "STATUS: PASS" \
	&& echo "DifDaq simulation passed" \
	|| { echo "DifDaq simulation failed"; exit 1; }
